// ==== sys_bus_top.f ====
design/sys_bus_pkg.sv
design/axi_gp_slave.sv
design/sys_bus_decoder.sv
design/sys_reg_bank.sv
design/sys_bus_return.sv
design/sys_bus_top.sv
bench/sys_bus_props.sv
bench/sys_bus_checker.sv
bench/tb_sys_bus_top.sv

// ==== Makefile ====
# Verilator build and run for the system bus testbench

VERILATOR ?= verilator
TOP       ?= tb_sys_bus_top
FILELIST  ?= sys_bus_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/tb_sys_bus_top.sv ====
////////////////////////////////////////////////////////////
// System bus testbench
// LFSR driven AXI reads and writes into the bus top level,
// cycle watchdog and the closing report
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_sys_bus_top
  import sys_bus_pkg::*;
();

  localparam int N_TXN        = 400;
  localparam int RESET_CYCLES = 10;
  // Per response: 5 latency, 8 ready delay, 4 handshake overhead
  localparam int RESP_CYCLES  = 5 + 8 + 4;
  // Room for two responses per transaction plus reset
  localparam int TIMEOUT_CYCLES = N_TXN * 2 * RESP_CYCLES + RESET_CYCLES + 200;

  logic      clk_i;
  logic      reset_i;
  logic      aw_valid_i;
  axi_addr_t aw_i;
  logic      aw_ready_o;
  logic      w_valid_i;
  axi_wdat_t w_i;
  logic      w_ready_o;
  logic      ar_valid_i;
  axi_addr_t ar_i;
  logic      ar_ready_o;
  logic      b_valid_o;
  axi_b_t    b_o;
  logic      b_ready_i;
  logic      r_valid_o;
  axi_r_t    r_o;
  logic      r_ready_i;

  logic [15:0] lfsr_q;
  int          n_resp_exp;

  sys_bus_top u_dut (
    .clk_i      (clk_i     ),
    .reset_i    (reset_i   ),
    .aw_valid_i (aw_valid_i),
    .aw_i       (aw_i      ),
    .aw_ready_o (aw_ready_o),
    .w_valid_i  (w_valid_i ),
    .w_i        (w_i       ),
    .w_ready_o  (w_ready_o ),
    .ar_valid_i (ar_valid_i),
    .ar_i       (ar_i      ),
    .ar_ready_o (ar_ready_o),
    .b_valid_o  (b_valid_o ),
    .b_o        (b_o       ),
    .b_ready_i  (b_ready_i ),
    .r_valid_o  (r_valid_o ),
    .r_o        (r_o       ),
    .r_ready_i  (r_ready_i )
  );

  sys_bus_checker u_checker (
    .clk_i      (clk_i     ),
    .reset_i    (reset_i   ),
    .aw_valid_i (aw_valid_i),
    .aw_i       (aw_i      ),
    .aw_ready_i (aw_ready_o),
    .w_valid_i  (w_valid_i ),
    .w_i        (w_i       ),
    .w_ready_i  (w_ready_o ),
    .ar_valid_i (ar_valid_i),
    .ar_i       (ar_i      ),
    .ar_ready_i (ar_ready_o),
    .b_valid_i  (b_valid_o ),
    .b_i        (b_o       ),
    .b_ready_i  (b_ready_i ),
    .r_valid_i  (r_valid_o ),
    .r_i        (r_o       ),
    .r_ready_i  (r_ready_i )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  function automatic logic [ADDR_W-1:0] make_addr(
    input logic [SLOT_W-1:0] region,
    input logic [1:0]        idx,
    input logic [7:0]        fill
  );
    logic [ADDR_W-1:0] a;
    a = '0;
    a[SLOT_LSB +: SLOT_W] = region;
    a[REG_IDX_LSB +: 2]   = idx;
    // Don't-care offset bits inside the bank
    a[11:4] = fill;
    return a;
  endfunction

  ////////////////////////////////////////////////////////////
  // AXI driver, entered and left on a rising edge
  ////////////////////////////////////////////////////////////

  task automatic send_write(input axi_addr_t a, input axi_wdat_t d);
    aw_valid_i <= 1'b1;
    aw_i       <= a;
    w_valid_i  <= 1'b1;
    w_i        <= d;
    do @(negedge clk_i); while (!aw_ready_o);
    @(posedge clk_i);
    aw_valid_i <= 1'b0;
    w_valid_i  <= 1'b0;
  endtask

  task automatic accept_read();
    do @(negedge clk_i); while (!ar_ready_o);
    @(posedge clk_i);
    ar_valid_i <= 1'b0;
  endtask

  // Response waits out the idle delay with ready low
  task automatic take_b(input int delay);
    do @(negedge clk_i); while (!b_valid_o);
    repeat (delay + 1) @(posedge clk_i);
    b_ready_i <= 1'b1;
    @(posedge clk_i);
    b_ready_i <= 1'b0;
  endtask

  task automatic take_r(input int delay);
    do @(negedge clk_i); while (!r_valid_o);
    repeat (delay + 1) @(posedge clk_i);
    r_ready_i <= 1'b1;
    @(posedge clk_i);
    r_ready_i <= 1'b0;
  endtask

  task automatic print_counts(input int missing);
    $display("Errors: %0d mismatches, %0d protocol, %0d missing responses",
             u_checker.mismatch_cnt, u_checker.proto_cnt, missing);
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [31:0]       v;
    logic              is_wr;
    logic              dual;
    logic [SLOT_W-1:0] region;
    logic [1:0]        idx;
    logic [7:0]        fill;
    logic [ID_W-1:0]   id;
    axi_addr_t         a;
    axi_addr_t         ra;
    axi_wdat_t         d;
    int                delay;
    int                missing;
    lfsr_q     = 16'd4870;
    n_resp_exp = 0;
    reset_i    = 1'b1;
    aw_valid_i = 1'b0;
    aw_i       = '0;
    w_valid_i  = 1'b0;
    w_i        = '0;
    ar_valid_i = 1'b0;
    ar_i       = '0;
    b_ready_i  = 1'b0;
    r_ready_i  = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    for (int t = 0; t < N_TXN; t++) begin
      draw(1, v);
      is_wr = v[0];
      draw(SLOT_W, v);
      region = v[SLOT_W-1:0];
      draw(2, v);
      idx = v[1:0];
      draw(8, v);
      fill = v[7:0];
      draw(ID_W, v);
      id = v[ID_W-1:0];
      draw(DATA_W, v);
      d.data = v;
      draw(STRB_W, v);
      d.strb = v[STRB_W-1:0];
      draw(3, v);
      delay = int'(v[2:0]);
      // One write in four also offers a read of the same word
      draw(2, v);
      dual    = is_wr && (v[1:0] == 2'b11);
      a.addr  = make_addr(region, idx, fill);
      a.id    = id;
      ra.addr = a.addr;
      ra.id   = id ^ 12'h001;
      if (is_wr) begin
        if (dual) begin
          ar_valid_i <= 1'b1;
          ar_i       <= ra;
        end
        send_write(a, d);
        take_b(delay);
        n_resp_exp++;
        if (dual) begin
          accept_read();
          take_r(delay);
          n_resp_exp++;
        end
      end else begin
        ar_valid_i <= 1'b1;
        ar_i       <= a;
        accept_read();
        take_r(delay);
        n_resp_exp++;
      end
    end
    repeat (4) @(posedge clk_i);
    missing = n_resp_exp - u_checker.resp_cnt;
    if (missing != 0) begin
      $display("Response count wrong: expected %0d, seen %0d", n_resp_exp, u_checker.resp_cnt);
    end
    print_counts(missing);
    if (u_checker.mismatch_cnt == 0 && u_checker.proto_cnt == 0 && missing == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
    print_counts(n_resp_exp - u_checker.resp_cnt);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== bench/sys_bus_checker.sv ====
////////////////////////////////////////////////////////////
// System bus checker
// Watches the AXI port, keeps a model of the four banks
// and compares every write and read response
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sys_bus_checker
  import sys_bus_pkg::*;
(
  input logic      clk_i,
  input logic      reset_i,
  input logic      aw_valid_i,
  input axi_addr_t aw_i,
  input logic      aw_ready_i,
  input logic      w_valid_i,
  input axi_wdat_t w_i,
  input logic      w_ready_i,
  input logic      ar_valid_i,
  input axi_addr_t ar_i,
  input logic      ar_ready_i,
  input logic      b_valid_i,
  input axi_b_t    b_i,
  input logic      b_ready_i,
  input logic      r_valid_i,
  input axi_r_t    r_i,
  input logic      r_ready_i
);

  localparam int SLOT_IDX_W = $clog2(N_SLOTS);

  int mismatch_cnt = 0;
  int proto_cnt    = 0;
  int resp_cnt     = 0;

  // Bank model
  logic [DATA_W-1:0] regs_m [N_SLOTS][REG_ID_IDX];
  logic [CNT_W-1:0]  cnt_m  [N_SLOTS];

  axi_b_t exp_b;
  axi_r_t exp_r;
  logic   b_pend;
  logic   r_pend;
  string  b_name;
  string  r_name;
  // Previous cycle, for the hold checks
  axi_b_t b_prev;
  axi_r_t r_prev;
  logic   b_hold;
  logic   r_hold;

  // Strobe mask per byte lane
  function automatic logic [DATA_W-1:0] apply_strobes(
    input logic [DATA_W-1:0] old_word,
    input logic [DATA_W-1:0] new_word,
    input logic [STRB_W-1:0] strb
  );
    logic [DATA_W-1:0] mask;
    for (int b = 0; b < STRB_W; b++) begin
      mask[8*b +: 8] = {8{strb[b]}};
    end
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  task automatic protocol_error(input string what);
    $display("Protocol error at %0t: %s", $time, what);
    proto_cnt++;
  endtask

  always @(posedge clk_i) begin : watch
    logic [SLOT_W-1:0]     region;
    logic [SLOT_IDX_W-1:0] slot;
    logic [1:0]            idx;
    logic [DATA_W-1:0]     word;
    if (reset_i) begin
      for (int s = 0; s < N_SLOTS; s++) begin
        for (int k = 0; k < REG_ID_IDX; k++) begin
          regs_m[s][k] = '0;
        end
        cnt_m[s] = '0;
      end
      b_pend = 1'b0;
      r_pend = 1'b0;
      b_hold = 1'b0;
      r_hold = 1'b0;
    end else begin
      ////////////////////////////////////////////////////////////
      // Accepted requests update the model
      ////////////////////////////////////////////////////////////
      if (aw_valid_i && aw_ready_i) begin
        if (!(w_valid_i && w_ready_i)) begin
          protocol_error("write address taken without write data");
        end
        region   = aw_i.addr[SLOT_LSB +: SLOT_W];
        slot     = region[SLOT_IDX_W-1:0];
        idx      = aw_i.addr[REG_IDX_LSB +: 2];
        exp_b.id = aw_i.id;
        if (int'(region) >= N_SLOTS) begin
          exp_b.resp = SLVERR;
          b_name     = "write_unmapped";
        end else begin
          exp_b.resp = OKAY;
          // Identity word ignores data but still counts
          if (int'(idx) < REG_ID_IDX) begin
            regs_m[slot][idx] = apply_strobes(regs_m[slot][idx], w_i.data, w_i.strb);
            b_name            = "write_reg";
          end else begin
            b_name = "write_id_reg";
          end
          cnt_m[slot] = cnt_m[slot] + 16'd1;
        end
        b_pend = 1'b1;
      end
      if (ar_valid_i && ar_ready_i) begin
        if (aw_valid_i && w_valid_i) begin
          protocol_error("read accepted while a write was offered");
        end
        region   = ar_i.addr[SLOT_LSB +: SLOT_W];
        slot     = region[SLOT_IDX_W-1:0];
        idx      = ar_i.addr[REG_IDX_LSB +: 2];
        exp_r.id = ar_i.id;
        word     = '0;
        if (int'(region) >= N_SLOTS) begin
          exp_r.resp = SLVERR;
          r_name     = "read_unmapped";
        end else begin
          exp_r.resp = OKAY;
          if (int'(idx) < REG_ID_IDX) begin
            word   = regs_m[slot][idx];
            r_name = "read_reg";
          end else begin
            word[31:16] = cnt_m[slot];
            word[7:0]   = 8'(slot);
            r_name      = "read_id_reg";
          end
        end
        exp_r.data = word;
        r_pend     = 1'b1;
      end
      ////////////////////////////////////////////////////////////
      // Responses
      ////////////////////////////////////////////////////////////
      if (b_valid_i && b_ready_i) begin
        if (!b_pend) begin
          protocol_error("write response without an accepted write");
        end else if (b_i !== exp_b) begin
          $display("Mismatch %s: expected %h, actual %h", b_name, exp_b, b_i);
          mismatch_cnt++;
        end
        b_pend = 1'b0;
        resp_cnt++;
      end
      if (r_valid_i && r_ready_i) begin
        if (!r_pend) begin
          protocol_error("read response without an accepted read");
        end else if (r_i !== exp_r) begin
          $display("Mismatch %s: expected %h, actual %h", r_name, exp_r, r_i);
          mismatch_cnt++;
        end
        r_pend = 1'b0;
        resp_cnt++;
      end
      // Back-pressure holds valid and payload
      if (b_hold && (!b_valid_i || b_i !== b_prev)) begin
        protocol_error("write response changed before it was taken");
      end
      if (r_hold && (!r_valid_i || r_i !== r_prev)) begin
        protocol_error("read response changed before it was taken");
      end
      if ((b_valid_i || r_valid_i) && (aw_ready_i || w_ready_i || ar_ready_i)) begin
        protocol_error("ready raised while a response was pending");
      end
      b_hold = b_valid_i && !b_ready_i;
      r_hold = r_valid_i && !r_ready_i;
      b_prev = b_i;
      r_prev = r_i;
    end
  end

endmodule

// ==== bench/sys_bus_props.sv ====
////////////////////////////////////////////////////////////
// AXI slave properties
// Handshake assertions bound into the AXI GP slave
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sys_bus_props
  import sys_bus_pkg::*;
(
  input logic     clk_i,
  input logic     reset_i,
  input logic     aw_valid_i,
  input logic     aw_ready_i,
  input logic     w_ready_i,
  input logic     ar_valid_i,
  input logic     ar_ready_i,
  input logic     b_valid_i,
  input axi_b_t   b_i,
  input logic     b_ready_i,
  input logic     r_valid_i,
  input axi_r_t   r_i,
  input logic     r_ready_i,
  input sys_req_t req_i
);

  logic addr_hs;
  logic strobe;

  assign addr_hs = (aw_valid_i && aw_ready_i) || (ar_valid_i && ar_ready_i);
  assign strobe  = req_i.wen || req_i.ren;

  a_ready_pair: assert property (@(posedge clk_i) disable iff (reset_i)
    aw_ready_i == w_ready_i)
    else $error("AW and W ready differ");

  a_one_resp: assert property (@(posedge clk_i) disable iff (reset_i)
    !(b_valid_i && r_valid_i))
    else $error("B and R valid high together");

  // Stalled responses stay put
  a_b_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_i))
    else $error("B response not held under back-pressure");

  a_r_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_i))
    else $error("R response not held under back-pressure");

  // Strobe exactly one cycle after the address handshake
  a_req_after_hs: assert property (@(posedge clk_i) disable iff (reset_i)
    addr_hs |=> strobe)
    else $error("No request strobe after address handshake");

  a_req_only_hs: assert property (@(posedge clk_i) disable iff (reset_i)
    strobe |-> $past(addr_hs))
    else $error("Request strobe without a preceding handshake");

endmodule

bind axi_gp_slave sys_bus_props u_props (
  .clk_i      (clk_i     ),
  .reset_i    (reset_i   ),
  .aw_valid_i (aw_valid_i),
  .aw_ready_i (aw_ready_o),
  .w_ready_i  (w_ready_o ),
  .ar_valid_i (ar_valid_i),
  .ar_ready_i (ar_ready_o),
  .b_valid_i  (b_valid_o ),
  .b_i        (b_o       ),
  .b_ready_i  (b_ready_i ),
  .r_valid_i  (r_valid_o ),
  .r_i        (r_o       ),
  .r_ready_i  (r_ready_i ),
  .req_i      (req_o     )
);

// ==== design/sys_bus_top.sv ====
////////////////////////////////////////////////////////////
// System bus top level
// AXI GP slave, address decoder, register banks and the
// return path to the AXI port
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sys_bus_top
  import sys_bus_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  // AXI write
  input  logic      aw_valid_i,
  input  axi_addr_t aw_i,
  output logic      aw_ready_o,
  input  logic      w_valid_i,
  input  axi_wdat_t w_i,
  output logic      w_ready_o,
  // AXI read
  input  logic      ar_valid_i,
  input  axi_addr_t ar_i,
  output logic      ar_ready_o,
  // AXI responses
  output logic      b_valid_o,
  output axi_b_t    b_o,
  input  logic      b_ready_i,
  output logic      r_valid_o,
  output axi_r_t    r_o,
  input  logic      r_ready_i
);

  sys_req_t sys_req;
  sys_rsp_t sys_rsp;
  sys_req_t slot_req [N_SLOTS];
  sys_rsp_t slot_rsp [N_SLOTS];
  logic     unmapped;

  axi_gp_slave u_slave (
    .clk_i      (clk_i     ),
    .reset_i    (reset_i   ),
    .aw_valid_i (aw_valid_i),
    .aw_i       (aw_i      ),
    .aw_ready_o (aw_ready_o),
    .w_valid_i  (w_valid_i ),
    .w_i        (w_i       ),
    .w_ready_o  (w_ready_o ),
    .ar_valid_i (ar_valid_i),
    .ar_i       (ar_i      ),
    .ar_ready_o (ar_ready_o),
    .b_valid_o  (b_valid_o ),
    .b_o        (b_o       ),
    .b_ready_i  (b_ready_i ),
    .r_valid_o  (r_valid_o ),
    .r_o        (r_o       ),
    .r_ready_i  (r_ready_i ),
    .req_o      (sys_req   ),
    .rsp_i      (sys_rsp   )
  );

  sys_bus_decoder u_decoder (
    .clk_i      (clk_i   ),
    .reset_i    (reset_i ),
    .req_i      (sys_req ),
    .slot_req_o (slot_req),
    .unmapped_o (unmapped)
  );

  ////////////////////////////////////////////////////////////
  // Register banks, one per slot
  ////////////////////////////////////////////////////////////

  for (genvar g = 0; g < N_SLOTS; g++) begin : gen_bank
    sys_reg_bank #(
      .SLOT_ID (g)
    ) u_bank (
      .clk_i   (clk_i      ),
      .reset_i (reset_i    ),
      .req_i   (slot_req[g]),
      .rsp_o   (slot_rsp[g])
    );
  end

  sys_bus_return u_return (
    .clk_i      (clk_i   ),
    .reset_i    (reset_i ),
    .slot_rsp_i (slot_rsp),
    .unmapped_i (unmapped),
    .rsp_o      (sys_rsp )
  );

endmodule

// ==== design/sys_bus_return.sv ====
////////////////////////////////////////////////////////////
// System bus return path
// Merges the bank answers and the unmapped flag into one
// registered response for the AXI slave
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sys_bus_return
  import sys_bus_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  sys_rsp_t slot_rsp_i [N_SLOTS],
  input  logic     unmapped_i,
  output sys_rsp_t rsp_o
);

  sys_rsp_t merged;

  ////////////////////////////////////////////////////////////
  // Merge
  ////////////////////////////////////////////////////////////

  // One slot answers at a time, so an OR of gated data is enough
  always_comb begin
    merged = '0;
    for (int s = 0; s < N_SLOTS; s++) begin
      merged.ack = merged.ack | slot_rsp_i[s].ack;
      merged.err = merged.err | (slot_rsp_i[s].ack & slot_rsp_i[s].err);
      if (slot_rsp_i[s].ack) begin
        merged.rdata = merged.rdata | slot_rsp_i[s].rdata;
      end
    end
    // Unmapped region, error with zero data
    if (unmapped_i) begin
      merged.ack   = 1'b1;
      merged.err   = 1'b1;
      merged.rdata = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_o <= '0;
    end else begin
      rsp_o <= merged;
    end
  end

endmodule

// ==== design/sys_reg_bank.sv ====
////////////////////////////////////////////////////////////
// Register bank
// Three byte-writable registers plus a read-only identity
// and write-count word, acked one cycle after each strobe
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sys_reg_bank
  import sys_bus_pkg::*;
#(
  parameter int unsigned SLOT_ID = 0
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  sys_req_t req_i,
  output sys_rsp_t rsp_o
);

  logic [DATA_W-1:0]    regs_q [REG_ID_IDX];
  logic [CNT_W-1:0]     wr_cnt_q;
  logic [REG_IDX_W-1:0] idx;
  logic [DATA_W-1:0]    id_word;
  logic [DATA_W-1:0]    rd_data;

  // Byte lanes with strobe set take the new data
  function automatic logic [DATA_W-1:0] merge_bytes(
    input logic [DATA_W-1:0] old_data,
    input logic [DATA_W-1:0] new_data,
    input logic [STRB_W-1:0] strb
  );
    logic [DATA_W-1:0] res;
    res = old_data;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_data[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign idx = req_i.addr[REG_IDX_LSB +: REG_IDX_W];

  // Count on top, slot number in the low byte
  assign id_word = {wr_cnt_q, {(DATA_W-CNT_W-SLOT_ID_W){1'b0}}, SLOT_ID_W'(SLOT_ID)};

  ////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    rd_data = id_word;
    for (int k = 0; k < REG_ID_IDX; k++) begin
      if (idx == REG_IDX_W'(k)) begin
        rd_data = regs_q[k];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int k = 0; k < REG_ID_IDX; k++) begin
        regs_q[k] <= '0;
      end
      wr_cnt_q <= '0;
      rsp_o    <= '0;
    end else begin
      for (int k = 0; k < REG_ID_IDX; k++) begin
        if (req_i.wen && (idx == REG_IDX_W'(k))) begin
          regs_q[k] <= merge_bytes(regs_q[k], req_i.wdata, req_i.strb);
        end
      end
      // Every acked write counts, the identity word too
      if (req_i.wen) begin
        wr_cnt_q <= wr_cnt_q + 1'b1;
      end
      rsp_o.ack   <= req_i.wen || req_i.ren;
      rsp_o.err   <= 1'b0;
      rsp_o.rdata <= req_i.ren ? rd_data : '0;
    end
  end

endmodule

// ==== design/sys_bus_decoder.sv ====
////////////////////////////////////////////////////////////
// System bus decoder
// Registers a request and steers its strobe to one bank
// slot, or flags the access as unmapped
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sys_bus_decoder
  import sys_bus_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  sys_req_t req_i,
  output sys_req_t slot_req_o [N_SLOTS],
  output logic     unmapped_o
);

  logic [SLOT_W-1:0] region;
  logic              mapped;
  logic [ADDR_W-1:0] local_addr;

  // Region field picks the slot
  assign region = req_i.addr[SLOT_LSB +: SLOT_W];
  assign mapped = (region < SLOT_W'(N_SLOTS));

  // Bank sees its own address space only
  always_comb begin
    local_addr                       = req_i.addr;
    local_addr[SLOT_LSB +: SLOT_W] = '0;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < N_SLOTS; s++) begin
        slot_req_o[s] <= '0;
      end
      unmapped_o <= 1'b0;
    end else begin
      for (int s = 0; s < N_SLOTS; s++) begin
        // Payload fans out to all slots
        slot_req_o[s].addr  <= local_addr;
        slot_req_o[s].wdata <= req_i.wdata;
        slot_req_o[s].strb  <= req_i.strb;
        // Strobes to the addressed slot only
        slot_req_o[s].wen   <= req_i.wen && mapped && (region == SLOT_W'(s));
        slot_req_o[s].ren   <= req_i.ren && mapped && (region == SLOT_W'(s));
      end
      // Nobody behind regions past the last slot
      unmapped_o <= (req_i.wen || req_i.ren) && !mapped;
    end
  end

endmodule

// ==== design/axi_gp_slave.sv ====
////////////////////////////////////////////////////////////
// AXI GP slave
// Turns single-beat AXI reads and writes into one system-bus
// request each and returns the AXI response when acked
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axi_gp_slave
  import sys_bus_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  // Write address and data
  input  logic       aw_valid_i,
  input  axi_addr_t  aw_i,
  output logic       aw_ready_o,
  input  logic       w_valid_i,
  input  axi_wdat_t  w_i,
  output logic       w_ready_o,
  // Read address
  input  logic       ar_valid_i,
  input  axi_addr_t  ar_i,
  output logic       ar_ready_o,
  // Write response
  output logic       b_valid_o,
  output axi_b_t     b_o,
  input  logic       b_ready_i,
  // Read response
  output logic       r_valid_o,
  output axi_r_t     r_o,
  input  logic       r_ready_i,
  // System bus
  output sys_req_t   req_o,
  input  sys_rsp_t   rsp_i
);

  axi_state_e      state_q;
  logic [ID_W-1:0] id_q;
  sys_req_t        req_q;
  axi_b_t          b_q;
  axi_r_t          r_q;
  logic            wr_go;
  logic            rd_go;
  axi_resp_e       resp;

  // Write needs both AW and W, and wins over a read
  assign wr_go = (state_q == ST_IDLE) && aw_valid_i && w_valid_i;
  assign rd_go = (state_q == ST_IDLE) && ar_valid_i && !(aw_valid_i && w_valid_i);

  // Readies pulse in the acceptance cycle only
  assign aw_ready_o = wr_go;
  assign w_ready_o  = wr_go;
  assign ar_ready_o = rd_go;

  assign resp = rsp_i.err ? SLVERR : OKAY;

  ////////////////////////////////////////////////////////////
  // Transaction FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
      id_q    <= '0;
      req_q   <= '0;
      b_q     <= '0;
      r_q     <= '0;
    end else begin
      // Strobes last a single cycle
      req_q.wen <= 1'b0;
      req_q.ren <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (wr_go) begin
            id_q        <= aw_i.id;
            req_q.addr  <= aw_i.addr;
            req_q.wdata <= w_i.data;
            req_q.strb  <= w_i.strb;
            req_q.wen   <= 1'b1;
            state_q     <= ST_WR_WAIT;
          end else if (rd_go) begin
            id_q        <= ar_i.id;
            req_q.addr  <= ar_i.addr;
            req_q.wdata <= '0;
            req_q.strb  <= '0;
            req_q.ren   <= 1'b1;
            state_q     <= ST_RD_WAIT;
          end
        end
        ST_WR_WAIT: begin
          if (rsp_i.ack) begin
            b_q     <= '{id: id_q, resp: resp};
            state_q <= ST_B_RESP;
          end
        end
        ST_RD_WAIT: begin
          if (rsp_i.ack) begin
            r_q     <= '{id: id_q, data: rsp_i.rdata, resp: resp};
            state_q <= ST_R_RESP;
          end
        end
        // Hold response until the manager takes it
        ST_B_RESP: begin
          if (b_ready_i) begin
            state_q <= ST_IDLE;
          end
        end
        ST_R_RESP: begin
          if (r_ready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign b_valid_o = (state_q == ST_B_RESP);
  assign r_valid_o = (state_q == ST_R_RESP);
  assign b_o       = b_q;
  assign r_o       = r_q;
  assign req_o     = req_q;

endmodule

// ==== design/sys_bus_pkg.sv ====
////////////////////////////////////////////////////////////
// System bus package
// Bus widths, address map, AXI and system-bus beat types
// and the AXI slave state encoding
////////////////////////////////////////////////////////////

package sys_bus_pkg;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int ID_W   = 12;
  localparam int STRB_W = DATA_W / 8;

  // Address map, region field selects the bank slot
  localparam int N_SLOTS  = 4;
  localparam int SLOT_LSB = 20;
  localparam int SLOT_W   = 3;

  // Register index inside a bank, word aligned
  localparam int REG_IDX_LSB = 2;
  localparam int REG_IDX_W   = 2;
  localparam int REG_ID_IDX  = 3;

  // Identity register fields
  localparam int CNT_W     = 16;
  localparam int SLOT_ID_W = 8;

  // AXI response codes, only the two we return
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  // AXI slave FSM
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WR_WAIT,
    ST_RD_WAIT,
    ST_B_RESP,
    ST_R_RESP
  } axi_state_e;

  ////////////////////////////////////////////////////////////
  // AXI channel beats
  ////////////////////////////////////////////////////////////

  // Shared by AW and AR
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [ID_W-1:0]   id;
  } axi_addr_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } axi_wdat_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    axi_resp_e       resp;
  } axi_b_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    axi_resp_e         resp;
  } axi_r_t;

  ////////////////////////////////////////////////////////////
  // System bus
  ////////////////////////////////////////////////////////////

  // One request, wen or ren high for a single cycle
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] strb;
    logic              wen;
    logic              ren;
  } sys_req_t;

  // One answer, ack is a single-cycle pulse
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              ack;
    logic              err;
  } sys_rsp_t;

endpackage
